//--- rtl/ppu_bus_pkg.sv
// Register bus definitions
// Opcodes, bus byte, status byte layout and counter type
`default_nettype none

package ppu_bus_pkg;

    // --------------------
    // Bus opcodes
    // --------------------
    typedef enum logic [5:0] {
        B_NOP,
        // Writes
        B_VMAIN,
        B_VMADDL,
        B_VMADDH,
        B_VMDATAL,
        B_VMDATAH,
        B_CGADD,
        B_CGDATA,
        B_M7A,
        B_M7B,
        B_SLHV,
        // Reads
        B_RDVRAML,
        B_RDVRAMH,
        B_RDCGRAM,
        B_MPYL,
        B_MPYM,
        B_MPYH,
        B_OPHCT,
        B_OPVCT,
        B_STAT78
    } b_op_t;

    typedef logic [7:0] bus_byte_t;

    // --------------------
    // Status and counters
    // --------------------
    localparam logic [4:0] STAT78_VERSION = 5'd2;
    localparam int CTR_W = 9;

    typedef logic [CTR_W-1:0] ctr_t;

    typedef struct packed {
        logic       field;
        logic       hv_latched;
        logic       zero;
        logic [4:0] version;
    } stat78_t;

endpackage

`default_nettype wire

//--- rtl/ppu_mem_pkg.sv
// VRAM and CGRAM definitions
// Sizes, address and word types, VMAIN layout, colour word, product type
`default_nettype none

package ppu_mem_pkg;

    localparam int VRAM_AW  = 15;
    localparam int CGRAM_AW = 8;

    typedef logic [VRAM_AW-1:0]  vram_addr_t;
    typedef logic [15:0]         vram_word_t;
    typedef logic [CGRAM_AW-1:0] cgram_addr_t;

    // VMAIN: remap 0 none, 1/2/3 rotate low 8/9/10 bits
    // step 0 by 1, 1 by 32, 2 and 3 by 128
    typedef struct packed {
        logic       incr_on_high;
        logic [1:0] remap;
        logic [1:0] step;
    } vmain_t;

    // --------------------
    // Palette entry
    // --------------------
    typedef union packed {
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
        struct packed {
            logic       pad;
            logic [4:0] b;
            logic [4:0] g;
            logic [4:0] r;
        } rgb;
    } color_word_t;

    typedef logic signed [23:0] mul_result_t;

endpackage

`default_nettype wire

//--- rtl/ppu_io_regs.sv
// Configuration registers
// VMAIN, mode-7 factors A/B with old-byte latch, signed multiplier
`timescale 1ns/1ns
`default_nettype none

module ppu_io_regs (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cpu_en,
    input  ppu_bus_pkg::b_op_t       b_op,
    input  ppu_bus_pkg::bus_byte_t   wdata,
    output ppu_mem_pkg::vmain_t      vmain,
    output ppu_mem_pkg::mul_result_t product
);

    logic signed [15:0]    fact_a;
    logic [15:0]           fact_b;
    ppu_bus_pkg::bus_byte_t old_byte;
    logic signed [7:0]     b_hi;

    always_ff @(posedge clk) begin
        if (reset) begin
            vmain    <= '0;
            fact_a   <= '0;
            fact_b   <= '0;
            old_byte <= '0;
        end else if (cpu_en) begin
            case (b_op)
                ppu_bus_pkg::B_VMAIN: begin
                    vmain <= {wdata[7], wdata[3:0]};
                end
                // New byte goes high, previous write fills the low half
                ppu_bus_pkg::B_M7A: begin
                    fact_a   <= {wdata, old_byte};
                    old_byte <= wdata;
                end
                ppu_bus_pkg::B_M7B: begin
                    fact_b   <= {wdata, old_byte};
                    old_byte <= wdata;
                end
                default: ;
            endcase
        end
    end

    // --------------------
    // Multiplier
    // --------------------
    assign b_hi    = fact_b[15:8];
    assign product = fact_a * b_hi;

endmodule

`default_nettype wire

//--- rtl/vram_port.sv
// VRAM CPU port
// Word array, address register with step increment, address remap,
// read prefetch latch
`timescale 1ns/1ns
`default_nettype none

module vram_port (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cpu_en,
    input  ppu_bus_pkg::b_op_t     b_op,
    input  ppu_bus_pkg::bus_byte_t wdata,
    input  ppu_mem_pkg::vmain_t    vmain,
    output ppu_mem_pkg::vram_word_t prefetch
);

    ppu_mem_pkg::vram_word_t vram [2**ppu_mem_pkg::VRAM_AW];

    ppu_mem_pkg::vram_addr_t addr_reg;
    ppu_mem_pkg::vram_addr_t access_addr;
    ppu_mem_pkg::vram_addr_t addr_map;
    ppu_mem_pkg::vram_addr_t step_amt;
    ppu_mem_pkg::vram_word_t rd_word;

    logic addr_wr;
    logic incr_hit;
    logic pf_load;

    assign addr_wr = (b_op == ppu_bus_pkg::B_VMADDL) || (b_op == ppu_bus_pkg::B_VMADDH);

    // Selected half, write or read
    assign incr_hit = vmain.incr_on_high
        ? ((b_op == ppu_bus_pkg::B_VMDATAH) || (b_op == ppu_bus_pkg::B_RDVRAMH))
        : ((b_op == ppu_bus_pkg::B_VMDATAL) || (b_op == ppu_bus_pkg::B_RDVRAML));

    assign pf_load = cpu_en && (addr_wr || (incr_hit &&
        ((b_op == ppu_bus_pkg::B_RDVRAML) || (b_op == ppu_bus_pkg::B_RDVRAMH))));

    // --------------------
    // Address path
    // --------------------
    always_comb begin
        case (b_op)
            ppu_bus_pkg::B_VMADDL: access_addr = {addr_reg[14:8], wdata};
            ppu_bus_pkg::B_VMADDH: access_addr = {wdata[6:0], addr_reg[7:0]};
            default:               access_addr = addr_reg;
        endcase
    end

    // Rotate low bits left by 3
    always_comb begin
        case (vmain.remap)
            2'd1:    addr_map = {access_addr[14:8], access_addr[4:0], access_addr[7:5]};
            2'd2:    addr_map = {access_addr[14:9], access_addr[5:0], access_addr[8:6]};
            2'd3:    addr_map = {access_addr[14:10], access_addr[6:0], access_addr[9:7]};
            default: addr_map = access_addr;
        endcase
    end

    always_comb begin
        case (vmain.step)
            2'd0:    step_amt = 15'd1;
            2'd1:    step_amt = 15'd32;
            default: step_amt = 15'd128;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            addr_reg <= '0;
        end else if (cpu_en) begin
            if (addr_wr) begin
                addr_reg <= access_addr;
            end else if (incr_hit) begin
                addr_reg <= addr_reg + step_amt;
            end
        end
    end

    // --------------------
    // Array and prefetch
    // --------------------
    always_ff @(posedge clk) begin
        if (cpu_en && (b_op == ppu_bus_pkg::B_VMDATAL)) begin
            vram[addr_map][7:0] <= wdata;
        end
        if (cpu_en && (b_op == ppu_bus_pkg::B_VMDATAH)) begin
            vram[addr_map][15:8] <= wdata;
        end
    end

    assign rd_word = vram[addr_map];

    // Pre-increment word, so a read returns the previous prefetch
    always_ff @(posedge clk) begin
        if (reset) begin
            prefetch <= '0;
        end else if (pf_load) begin
            prefetch <= rd_word;
        end
    end

    // Address write and step increment never share a prefetch load
    a_pf_addr_only: assert property (@(posedge clk) disable iff (reset)
        pf_load |-> !(addr_wr && incr_hit));

endmodule

`default_nettype wire

//--- rtl/cgram_port.sv
// CGRAM CPU port
// Palette array, address/toggle counter, byte-wide read and write
`timescale 1ns/1ns
`default_nettype none

module cgram_port (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cpu_en,
    input  ppu_bus_pkg::b_op_t     b_op,
    input  ppu_bus_pkg::bus_byte_t wdata,
    output ppu_bus_pkg::bus_byte_t cg_rdata
);

    ppu_mem_pkg::color_word_t cgram [2**ppu_mem_pkg::CGRAM_AW];

    // Palette index above the low/high toggle
    logic [ppu_mem_pkg::CGRAM_AW:0] cg_ctr;
    ppu_mem_pkg::cgram_addr_t       idx;
    logic                           tgl;
    ppu_mem_pkg::color_word_t       rd_word;
    logic                           data_wr;

    assign idx     = cg_ctr[ppu_mem_pkg::CGRAM_AW:1];
    assign tgl     = cg_ctr[0];
    assign data_wr = cpu_en && (b_op == ppu_bus_pkg::B_CGDATA);

    always_ff @(posedge clk) begin
        if (reset) begin
            cg_ctr <= '0;
        end else if (cpu_en) begin
            case (b_op)
                ppu_bus_pkg::B_CGADD:   cg_ctr <= {wdata, 1'b0};
                ppu_bus_pkg::B_CGDATA:  cg_ctr <= cg_ctr + 1'b1;
                ppu_bus_pkg::B_RDCGRAM: cg_ctr <= cg_ctr + 1'b1;
                default: ;
            endcase
        end
    end

    // --------------------
    // Array access
    // --------------------
    always_ff @(posedge clk) begin
        if (data_wr && !tgl) begin
            cgram[idx].bytes.lo <= wdata;
        end
        if (data_wr && tgl) begin
            cgram[idx].bytes.hi <= {1'b0, wdata[6:0]};
        end
    end

    assign rd_word  = cgram[idx];
    assign cg_rdata = tgl ? {1'b0, rd_word.bytes.hi[6:0]} : rd_word.bytes.lo;

    // Stored pad bit, seen on a high-byte read
    a_pad_zero: assert property (@(posedge clk) disable iff (reset)
        (cpu_en && (b_op == ppu_bus_pkg::B_RDCGRAM) && tgl) |-> (rd_word.rgb.pad == 1'b0));

endmodule

`default_nettype wire

//--- rtl/hv_latch.sv
// H/V counter latch
// Latched counters, per-counter read toggles, latched flag and status byte
`timescale 1ns/1ns
`default_nettype none

module hv_latch (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cpu_en,
    input  ppu_bus_pkg::b_op_t     b_op,
    input  ppu_bus_pkg::ctr_t      h_ctr,
    input  ppu_bus_pkg::ctr_t      v_ctr,
    input  logic                   field,
    output ppu_bus_pkg::bus_byte_t hv_rdata,
    output ppu_bus_pkg::stat78_t   status
);

    ppu_bus_pkg::ctr_t h_lat;
    ppu_bus_pkg::ctr_t v_lat;
    logic              flag;
    logic              h_tgl;
    logic              v_tgl;

    // Low byte first, then bit 8
    function automatic ppu_bus_pkg::bus_byte_t ctr_byte(ppu_bus_pkg::ctr_t c, logic hi);
        return hi ? {7'd0, c[ppu_bus_pkg::CTR_W-1]} : c[7:0];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            h_lat <= '0;
            v_lat <= '0;
            flag  <= 1'b0;
            h_tgl <= 1'b0;
            v_tgl <= 1'b0;
        end else if (cpu_en) begin
            case (b_op)
                ppu_bus_pkg::B_SLHV: begin
                    h_lat <= h_ctr;
                    v_lat <= v_ctr;
                    flag  <= 1'b1;
                end
                ppu_bus_pkg::B_OPHCT: h_tgl <= ~h_tgl;
                ppu_bus_pkg::B_OPVCT: v_tgl <= ~v_tgl;
                ppu_bus_pkg::B_STAT78: begin
                    flag  <= 1'b0;
                    h_tgl <= 1'b0;
                    v_tgl <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (b_op)
            ppu_bus_pkg::B_OPHCT: hv_rdata = ctr_byte(h_lat, h_tgl);
            ppu_bus_pkg::B_OPVCT: hv_rdata = ctr_byte(v_lat, v_tgl);
            default:              hv_rdata = '0;
        endcase
    end

    assign status = '{field: field, hv_latched: flag, zero: 1'b0,
                      version: ppu_bus_pkg::STAT78_VERSION};

    a_stat_clear: assert property (@(posedge clk) disable iff (reset)
        (cpu_en && (b_op == ppu_bus_pkg::B_STAT78)) |=> (!flag && !h_tgl && !v_tgl));

endmodule

`default_nettype wire

//--- rtl/ppu_bus_top.sv
// Register block top level
// Config registers, VRAM/CGRAM ports, H/V latch and read-data selector
`timescale 1ns/1ns
`default_nettype none

module ppu_bus_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   cpu_en,
    input  ppu_bus_pkg::b_op_t     b_op,
    input  ppu_bus_pkg::bus_byte_t wdata,
    input  ppu_bus_pkg::ctr_t      h_ctr,
    input  ppu_bus_pkg::ctr_t      v_ctr,
    input  logic                   field,
    output ppu_bus_pkg::bus_byte_t rdata
);

    ppu_mem_pkg::vmain_t      vmain;
    ppu_mem_pkg::mul_result_t product;
    ppu_mem_pkg::vram_word_t  prefetch;
    ppu_bus_pkg::bus_byte_t   cg_rdata;
    ppu_bus_pkg::bus_byte_t   hv_rdata;
    ppu_bus_pkg::stat78_t     status;

    // --------------------
    // Blocks
    // --------------------
    ppu_io_regs u_io_regs (
        .clk, .reset, .cpu_en, .b_op, .wdata,
        .vmain, .product
    );

    vram_port u_vram_port (
        .clk, .reset, .cpu_en, .b_op, .wdata,
        .vmain, .prefetch
    );

    cgram_port u_cgram_port (
        .clk, .reset, .cpu_en, .b_op, .wdata,
        .cg_rdata
    );

    hv_latch u_hv_latch (
        .clk, .reset, .cpu_en, .b_op,
        .h_ctr, .v_ctr, .field,
        .hv_rdata, .status
    );

    // --------------------
    // Read data
    // --------------------
    always_comb begin
        case (b_op)
            ppu_bus_pkg::B_RDVRAML: rdata = prefetch[7:0];
            ppu_bus_pkg::B_RDVRAMH: rdata = prefetch[15:8];
            ppu_bus_pkg::B_RDCGRAM: rdata = cg_rdata;
            ppu_bus_pkg::B_MPYL:    rdata = product[7:0];
            ppu_bus_pkg::B_MPYM:    rdata = product[15:8];
            ppu_bus_pkg::B_MPYH:    rdata = product[23:16];
            ppu_bus_pkg::B_OPHCT,
            ppu_bus_pkg::B_OPVCT:   rdata = hv_rdata;
            ppu_bus_pkg::B_STAT78:  rdata = status;
            default:                rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- dv/tb_ppu_bus.sv
// Testbench for the register block
// Stimulus table built from VRAM, CGRAM, multiplier and H/V models,
// applied in a loop with compare tasks and a watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_ppu_bus;

    typedef enum logic [1:0] {CHK_NONE, CHK_DATA, CHK_STAT} chk_t;

    typedef struct packed {
        ppu_bus_pkg::b_op_t     op;
        ppu_bus_pkg::bus_byte_t wdata;
        ppu_bus_pkg::ctr_t      h_ctr;
        ppu_bus_pkg::ctr_t      v_ctr;
        logic                   field;
        chk_t                   kind;
        ppu_bus_pkg::bus_byte_t want;
    } entry_t;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   cpu_en;
    ppu_bus_pkg::b_op_t     b_op;
    ppu_bus_pkg::bus_byte_t wdata;
    ppu_bus_pkg::ctr_t      h_ctr;
    ppu_bus_pkg::ctr_t      v_ctr;
    logic                   field;
    ppu_bus_pkg::bus_byte_t rdata;

    entry_t table_q[$];
    logic   table_built = 1'b0;
    integer seed = 32'h68ba_accc;
    int     data_errors = 0;
    int     status_errors = 0;

    // Values driven with the entries being built
    ppu_bus_pkg::ctr_t cur_h = '0;
    ppu_bus_pkg::ctr_t cur_v = '0;
    logic              cur_field = 1'b0;

    // --------------------
    // Reference models
    // --------------------
    logic [15:0]             vram_m [32768];
    ppu_mem_pkg::vram_addr_t m_addr = '0;
    logic [15:0]             m_pf = '0;
    logic                    m_incr_high = 1'b0;
    logic [1:0]              m_remap = '0;
    logic [1:0]              m_step = '0;
    logic [15:0]             cg_m [256];
    logic [8:0]              cg_ctr_m = '0;
    logic [15:0]             a_m = '0;
    logic [15:0]             b_m = '0;
    logic [7:0]              old_m = '0;
    ppu_bus_pkg::ctr_t       h_lat_m = '0;
    ppu_bus_pkg::ctr_t       v_lat_m = '0;
    logic                    flag_m = 1'b0;
    logic                    h_tgl_m = 1'b0;
    logic                    v_tgl_m = 1'b0;

    ppu_bus_top dut (
        .clk(clk),
        .reset(reset),
        .cpu_en(cpu_en),
        .b_op(b_op),
        .wdata(wdata),
        .h_ctr(h_ctr),
        .v_ctr(v_ctr),
        .field(field),
        .rdata(rdata)
    );

    always #20 clk = ~clk;

    function automatic ppu_bus_pkg::bus_byte_t rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // Left rotate by 3 inside the low 8, 9 or 10 bits
    function automatic ppu_mem_pkg::vram_addr_t rotate_addr(ppu_mem_pkg::vram_addr_t a,
                                                            logic [1:0] remap);
        int ai;
        int n;
        int mask;
        int low;
        ai = int'(a);
        n = 7 + int'(remap);
        mask = (1 << n) - 1;
        low = ai & mask;
        if (remap == 2'd0) begin
            return a;
        end
        return ppu_mem_pkg::vram_addr_t'((ai & ~mask) | (((low << 3) | (low >> (n - 3))) & mask));
    endfunction

    function automatic ppu_mem_pkg::vram_addr_t step_size(logic [1:0] step);
        if (step == 2'd0) begin
            return 15'd1;
        end
        return (step == 2'd1) ? 15'd32 : 15'd128;
    endfunction

    task automatic add(ppu_bus_pkg::b_op_t op, ppu_bus_pkg::bus_byte_t wd, chk_t kind,
                       ppu_bus_pkg::bus_byte_t want);
        entry_t e;
        e.op = op;
        e.wdata = wd;
        e.h_ctr = cur_h;
        e.v_ctr = cur_v;
        e.field = cur_field;
        e.kind = kind;
        e.want = want;
        table_q.push_back(e);
    endtask

    task automatic vmain_set(logic incr_high, logic [1:0] remap, logic [1:0] step);
        m_incr_high = incr_high;
        m_remap = remap;
        m_step = step;
        add(ppu_bus_pkg::B_VMAIN, {incr_high, 3'b000, remap, step}, CHK_NONE, 8'h00);
    endtask

    // Each address byte reloads the prefetch from the new address
    task automatic vaddr_set(ppu_mem_pkg::vram_addr_t a);
        m_addr = {m_addr[14:8], a[7:0]};
        m_pf = vram_m[rotate_addr(m_addr, m_remap)];
        add(ppu_bus_pkg::B_VMADDL, a[7:0], CHK_NONE, 8'h00);
        m_addr = a;
        m_pf = vram_m[rotate_addr(m_addr, m_remap)];
        add(ppu_bus_pkg::B_VMADDH, {1'b0, a[14:8]}, CHK_NONE, 8'h00);
    endtask

    task automatic vdata_write(logic high, ppu_bus_pkg::bus_byte_t b);
        ppu_mem_pkg::vram_addr_t pa;
        ppu_bus_pkg::b_op_t      op;
        pa = rotate_addr(m_addr, m_remap);
        if (high) begin
            vram_m[pa][15:8] = b;
            op = ppu_bus_pkg::B_VMDATAH;
        end else begin
            vram_m[pa][7:0] = b;
            op = ppu_bus_pkg::B_VMDATAL;
        end
        if (high == m_incr_high) begin
            m_addr = m_addr + step_size(m_step);
        end
        add(op, b, CHK_NONE, 8'h00);
    endtask

    task automatic vdata_read(logic high);
        ppu_bus_pkg::bus_byte_t want;
        ppu_bus_pkg::b_op_t     op;
        want = high ? m_pf[15:8] : m_pf[7:0];
        op = high ? ppu_bus_pkg::B_RDVRAMH : ppu_bus_pkg::B_RDVRAML;
        if (high == m_incr_high) begin
            m_pf = vram_m[rotate_addr(m_addr, m_remap)];
            m_addr = m_addr + step_size(m_step);
        end
        add(op, 8'h00, CHK_DATA, want);
    endtask

    task automatic cg_addr_set(ppu_mem_pkg::cgram_addr_t idx);
        cg_ctr_m = {idx, 1'b0};
        add(ppu_bus_pkg::B_CGADD, idx, CHK_NONE, 8'h00);
    endtask

    task automatic cg_write(ppu_bus_pkg::bus_byte_t b);
        if (cg_ctr_m[0]) begin
            cg_m[cg_ctr_m[8:1]][15:8] = {1'b0, b[6:0]};
        end else begin
            cg_m[cg_ctr_m[8:1]][7:0] = b;
        end
        cg_ctr_m = cg_ctr_m + 9'd1;
        add(ppu_bus_pkg::B_CGDATA, b, CHK_NONE, 8'h00);
    endtask

    task automatic cg_read();
        ppu_bus_pkg::bus_byte_t want;
        want = cg_ctr_m[0] ? {1'b0, cg_m[cg_ctr_m[8:1]][14:8]} : cg_m[cg_ctr_m[8:1]][7:0];
        cg_ctr_m = cg_ctr_m + 9'd1;
        add(ppu_bus_pkg::B_RDCGRAM, 8'h00, CHK_DATA, want);
    endtask

    task automatic m7_write(logic is_b, ppu_bus_pkg::bus_byte_t b);
        if (is_b) begin
            b_m = {b, old_m};
            add(ppu_bus_pkg::B_M7B, b, CHK_NONE, 8'h00);
        end else begin
            a_m = {b, old_m};
            add(ppu_bus_pkg::B_M7A, b, CHK_NONE, 8'h00);
        end
        old_m = b;
    endtask

    task automatic mult_read();
        int p;
        p = int'($signed(a_m)) * int'($signed(b_m[15:8]));
        add(ppu_bus_pkg::B_MPYL, 8'h00, CHK_DATA, p[7:0]);
        add(ppu_bus_pkg::B_MPYM, 8'h00, CHK_DATA, p[15:8]);
        add(ppu_bus_pkg::B_MPYH, 8'h00, CHK_DATA, p[23:16]);
    endtask

    task automatic slhv();
        h_lat_m = cur_h;
        v_lat_m = cur_v;
        flag_m = 1'b1;
        add(ppu_bus_pkg::B_SLHV, 8'h00, CHK_NONE, 8'h00);
    endtask

    task automatic opct_read(logic vert);
        ppu_bus_pkg::ctr_t      c;
        logic                   t;
        ppu_bus_pkg::bus_byte_t want;
        c = vert ? v_lat_m : h_lat_m;
        t = vert ? v_tgl_m : h_tgl_m;
        want = t ? {7'd0, c[8]} : c[7:0];
        if (vert) begin
            v_tgl_m = !v_tgl_m;
            add(ppu_bus_pkg::B_OPVCT, 8'h00, CHK_DATA, want);
        end else begin
            h_tgl_m = !h_tgl_m;
            add(ppu_bus_pkg::B_OPHCT, 8'h00, CHK_DATA, want);
        end
    endtask

    task automatic stat_read();
        ppu_bus_pkg::stat78_t s;
        s.field = cur_field;
        s.hv_latched = flag_m;
        s.zero = 1'b0;
        s.version = 5'd2;
        flag_m = 1'b0;
        h_tgl_m = 1'b0;
        v_tgl_m = 1'b0;
        add(ppu_bus_pkg::B_STAT78, 8'h00, CHK_STAT, s);
    endtask

    // --------------------
    // Stimulus table
    // --------------------
    task automatic build_table();
        ppu_mem_pkg::vram_addr_t base;
        ppu_mem_pkg::vram_addr_t va;
        ppu_bus_pkg::bus_byte_t  hi_b;
        logic [2:0]              cfg_incr;
        logic [5:0]              cfg_remap;
        logic [5:0]              cfg_step;
        ppu_mem_pkg::cgram_addr_t cg_idx;
        cfg_incr = 3'b101;
        cfg_remap = {2'd3, 2'd2, 2'd1};
        cfg_step = {2'd3, 2'd2, 2'd1};
        // Reset state
        stat_read();
        mult_read();
        // VRAM run at step 1
        vmain_set(1'b1, 2'd0, 2'd0);
        hi_b = rand_byte();
        base = {hi_b[6:0], rand_byte()};
        vaddr_set(base);
        for (int i = 0; i < 6; i++) begin
            vdata_write(1'b0, rand_byte());
            vdata_write(1'b1, rand_byte());
        end
        vaddr_set(base);
        for (int i = 0; i < 6; i++) begin
            vdata_read(1'b0);
            vdata_read(1'b1);
        end
        // Larger steps with each remap
        for (int c = 0; c < 3; c++) begin
            vmain_set(cfg_incr[c], cfg_remap[2*c +: 2], cfg_step[2*c +: 2]);
            hi_b = rand_byte();
            base = {hi_b[6:0], rand_byte()};
            vaddr_set(base);
            for (int i = 0; i < 4; i++) begin
                vdata_write(!m_incr_high, rand_byte());
                vdata_write(m_incr_high, rand_byte());
            end
            vaddr_set(base);
            for (int i = 0; i < 4; i++) begin
                vdata_read(1'b0);
                vdata_read(1'b1);
            end
            // Same words at their physical addresses, remap off
            vmain_set(1'b1, 2'd0, 2'd0);
            va = base;
            for (int i = 0; i < 4; i++) begin
                vaddr_set(rotate_addr(va, cfg_remap[2*c +: 2]));
                vdata_read(1'b0);
                vdata_read(1'b1);
                va = va + step_size(cfg_step[2*c +: 2]);
            end
        end
        // CGRAM pairs, high bytes written with bit 7 set
        cg_idx = rand_byte();
        cg_addr_set(cg_idx);
        for (int i = 0; i < 4; i++) begin
            cg_write(rand_byte());
            cg_write(rand_byte() | 8'h80);
        end
        cg_addr_set(cg_idx);
        for (int i = 0; i < 8; i++) begin
            cg_read();
        end
        // Multiplier, negative A then negative B
        m7_write(1'b0, 8'h18);
        m7_write(1'b0, 8'hfc);
        m7_write(1'b1, rand_byte());
        m7_write(1'b1, 8'h35);
        mult_read();
        m7_write(1'b0, rand_byte());
        m7_write(1'b0, rand_byte() & 8'h7f);
        m7_write(1'b1, rand_byte());
        m7_write(1'b1, rand_byte() | 8'h80);
        mult_read();
        m7_write(1'b0, 8'hff);
        m7_write(1'b0, 8'h7f);
        m7_write(1'b1, 8'h00);
        m7_write(1'b1, 8'h80);
        mult_read();
        // H/V latch
        cur_h = 9'h1a5;
        cur_v = 9'h13c;
        cur_field = 1'b1;
        slhv();
        cur_h = 9'h022;
        cur_v = 9'h0f0;
        opct_read(1'b0);
        opct_read(1'b0);
        opct_read(1'b1);
        opct_read(1'b1);
        opct_read(1'b0);
        stat_read();
        stat_read();
        opct_read(1'b0);
    endtask

    task automatic check_data(ppu_bus_pkg::bus_byte_t got, ppu_bus_pkg::bus_byte_t want,
                              int idx, ppu_bus_pkg::b_op_t op);
        if (got !== want) begin
            data_errors++;
            $display("[ERROR] %0t: entry %0d %s read 0x%02h, expected 0x%02h",
                     $time, idx, op.name(), got, want);
        end
    endtask

    // Status shown as field/latched/zero/version
    task automatic check_status(ppu_bus_pkg::stat78_t got, ppu_bus_pkg::stat78_t want,
                                int idx);
        if (got !== want) begin
            status_errors++;
            $display("[ERROR] %0t: entry %0d status %0b/%0b/%0b/%0d, expected %0b/%0b/%0b/%0d",
                     $time, idx, got.field, got.hv_latched, got.zero, got.version,
                     want.field, want.hv_latched, want.zero, want.version);
        end
    endtask

    initial begin
        reset = 1'b1;
        cpu_en = 1'b0;
        b_op = ppu_bus_pkg::B_NOP;
        wdata = '0;
        h_ctr = '0;
        v_ctr = '0;
        field = 1'b0;
        build_table();
        table_built = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < table_q.size(); i++) begin
            @(negedge clk);
            cpu_en = 1'b1;
            b_op = table_q[i].op;
            wdata = table_q[i].wdata;
            h_ctr = table_q[i].h_ctr;
            v_ctr = table_q[i].v_ctr;
            field = table_q[i].field;
            // Read data settles well before the next rising edge
            #10;
            if (table_q[i].kind == CHK_DATA) begin
                check_data(rdata, table_q[i].want, i, table_q[i].op);
            end else if (table_q[i].kind == CHK_STAT) begin
                check_status(ppu_bus_pkg::stat78_t'(rdata),
                             ppu_bus_pkg::stat78_t'(table_q[i].want), i);
            end
        end
        @(negedge clk);
        cpu_en = 1'b0;
        b_op = ppu_bus_pkg::B_NOP;
        $display("Errors: data %0d, status %0d", data_errors, status_errors);
        if (data_errors + status_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // --------------------
    // Watchdog
    // --------------------
    initial begin
        wait (table_built);
        #((table_q.size() + 5 + 50) * 40);
        $display("Watchdog: the run timed out before the table was applied");
        $display("Errors: data %0d, status %0d", data_errors, status_errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
rtl/ppu_bus_pkg.sv
rtl/ppu_mem_pkg.sv
rtl/ppu_io_regs.sv
rtl/vram_port.sv
rtl/cgram_port.sv
rtl/hv_latch.sv
rtl/ppu_bus_top.sv
dv/tb_ppu_bus.sv

//--- run.sh
#!/bin/sh
# Build the register block testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_ppu_bus \
    --Mdir obj_dir -o sim_ppu_bus
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_ppu_bus)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1
